// ==== design/xgmii_rx_cfg.svh ====
`ifndef XGMII_RX_CFG_SVH
`define XGMII_RX_CFG_SVH

////////////////////
// XGMII control characters

// Start of frame, only legal in lane 3
`define XGMII_CTL_START		8'hfb
// Terminate, may land in any lane
`define XGMII_CTL_END		8'hfd
`define XGMII_CTL_ERROR		8'hfe
`define XGMII_CTL_IDLE		8'h07

// Last three preamble bytes plus SFD, the one word after the start word
`define XGMII_PREAMBLE_SFD	32'h555555d5

////////////////////
// Bus widths

`define XGMII_LANES			4
// Byte count per word, 0 to 4
`define XGMII_BYTES_W		3

////////////////////
// CRC-32 constants

// Reflected form of 04c11db7
`define CRC32_POLY			32'hedb88320
`define CRC32_INIT			32'hffffffff

`endif

// ==== design/xgmii_rx_pkg.sv ====
`default_nettype none

`include "xgmii_rx_cfg.svh"

package xgmii_rx_pkg;

	////////////////////
	// XGMII data word

	// One 32-bit word off the XGMII receive bus
	// Seen either as a whole word or as four byte lanes
	// Lane 3 is bits 31:24 and carries the first byte on the wire
	typedef union packed {
		logic [31:0]					word;
		logic [`XGMII_LANES-1:0][7:0]	lane;
	} xgmii_word_u;

	////////////////////
	// Framer state

	// Idle waits for a start, preamble checks the SFD word, body streams data
	typedef enum logic [1:0] {
		RX_IDLE		= 2'd0,
		RX_PREAMBLE	= 2'd1,
		RX_BODY		= 2'd2
	} rx_state_t;

endpackage

`default_nettype wire

// ==== design/xgmii_lane_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xgmii_rx_cfg.svh"

module xgmii_lane_decoder (
	// Raw receive word and its control flags
	input wire [`XGMII_LANES-1:0]		xgmii_rx_ctl,
	input wire xgmii_rx_pkg::xgmii_word_u	xgmii_rx_data,

	// Per-lane terminate and error flags
	output logic [`XGMII_LANES-1:0]		lane_has_end,
	output logic [`XGMII_LANES-1:0]		lane_has_error,

	// Start character seen in lane 3
	output logic						has_start
);

	////////////////////
	// Control character decode

	always_comb begin
		// A lane only counts when its control flag is set
		// Data bytes of the same value are payload
		for (int i = 0; i < `XGMII_LANES; i++) begin
			lane_has_end[i] =
				xgmii_rx_ctl[i] && (xgmii_rx_data.lane[i] == `XGMII_CTL_END);
			lane_has_error[i] =
				xgmii_rx_ctl[i] && (xgmii_rx_data.lane[i] == `XGMII_CTL_ERROR);
		end

		// Start is aligned to the leftmost lane by the PCS
		// Anything in the other lanes is ignored
		has_start =
			xgmii_rx_ctl[`XGMII_LANES-1] &&
			(xgmii_rx_data.lane[`XGMII_LANES-1] == `XGMII_CTL_START);
	end

endmodule

`default_nettype wire

// ==== design/eth_rx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xgmii_rx_cfg.svh"

module eth_rx_framer (
	input wire								xgmii_rx_clk,
	input wire								reset,

	// Receive word, already split into lane flags by the decoder
	input wire								xgmii_rx_valid,
	input wire [`XGMII_LANES-1:0]			xgmii_rx_ctl,
	input wire xgmii_rx_pkg::xgmii_word_u	xgmii_rx_data,
	input wire [`XGMII_LANES-1:0]			lane_has_end,
	input wire [`XGMII_LANES-1:0]			lane_has_error,
	input wire								has_start,

	// Running CRC of the delivered bytes
	input wire [31:0]						crc_out,

	// Stream to the upper layer, also feeds the CRC engine
	output logic							rx_start,
	output logic							rx_data_valid,
	output logic [`XGMII_BYTES_W-1:0]		rx_bytes_valid,
	output logic [31:0]						rx_data,
	output logic							rx_commit,
	output logic							rx_drop,
	output logic							crc_ce
);

	xgmii_rx_pkg::rx_state_t	rx_state;

	// Held word is the preamble, not data
	logic			last_was_preamble;

	// FCS as received, lined up with the CRC engine latency
	logic [31:0]	crc_expected;
	logic [31:0]	crc_expected_ff;
	logic [31:0]	crc_expected_ff2;
	logic			fcs_pending_0;
	logic			fcs_pending_1;

	// Engine only advances on real words
	assign crc_ce = xgmii_rx_valid;

	////////////////////
	// Byte count and expected FCS

	always_comb begin
		rx_data_valid	= 1'b0;
		rx_bytes_valid	= 3'd0;
		crc_expected	= 32'h0;

		// Nothing goes out on a stall or on a corrupted word
		if ((rx_state == xgmii_rx_pkg::RX_BODY) && xgmii_rx_valid &&
			(lane_has_error == '0)) begin
			// Held word is all FCS
			if (lane_has_end[3]) begin
				crc_expected	= rx_data;
			end
			// FCS straddles the held word and the current one
			else if (lane_has_end[2]) begin
				rx_data_valid	= 1'b1;
				rx_bytes_valid	= 3'd1;
				crc_expected	= {rx_data[23:0], xgmii_rx_data.word[31:24]};
			end
			else if (lane_has_end[1]) begin
				rx_data_valid	= 1'b1;
				rx_bytes_valid	= 3'd2;
				crc_expected	= {rx_data[15:0], xgmii_rx_data.word[31:16]};
			end
			else if (lane_has_end[0]) begin
				rx_data_valid	= 1'b1;
				rx_bytes_valid	= 3'd3;
				crc_expected	= {rx_data[7:0], xgmii_rx_data.word[31:8]};
			end
			// No end yet, so the held word is data
			// Current word may still turn out to be FCS
			else if (!last_was_preamble) begin
				rx_data_valid	= 1'b1;
				rx_bytes_valid	= 3'd4;
			end
		end
	end

	////////////////////
	// Word and FCS pipeline

	always_ff @(posedge xgmii_rx_clk) begin
		if (xgmii_rx_valid) begin
			rx_data				<= xgmii_rx_data.word;
			crc_expected_ff		<= crc_expected;
			crc_expected_ff2	<= crc_expected_ff;
		end
	end

	////////////////////
	// Frame state machine

	always_ff @(posedge xgmii_rx_clk) begin
		if (reset) begin
			rx_state			<= xgmii_rx_pkg::RX_IDLE;
			rx_start			<= 1'b0;
			rx_commit			<= 1'b0;
			rx_drop				<= 1'b0;
			last_was_preamble	<= 1'b0;
			fcs_pending_0		<= 1'b0;
			fcs_pending_1		<= 1'b0;
		end else begin
			rx_start	<= 1'b0;
			rx_commit	<= 1'b0;
			rx_drop		<= 1'b0;

			// CRC has taken in the last word, check it on this edge
			// May overlap the preamble of the next frame
			if (fcs_pending_1) begin
				fcs_pending_1	<= 1'b0;
				if (crc_expected_ff2 == crc_out)
					rx_commit	<= 1'b1;
				else
					rx_drop		<= 1'b1;
			end

			if (xgmii_rx_valid) begin
				last_was_preamble	<= 1'b0;
				fcs_pending_0		<= 1'b0;
				fcs_pending_1		<= fcs_pending_0;

				case (rx_state)
					xgmii_rx_pkg::RX_IDLE: begin
						// Idles and stray errors between frames are ignored
						if (has_start)
							rx_state	<= xgmii_rx_pkg::RX_PREAMBLE;
					end

					xgmii_rx_pkg::RX_PREAMBLE: begin
						// Exactly one word of 55 55 55 d5, all data
						// Anything else abandons the frame silently
						if ((xgmii_rx_ctl == '0) &&
							(xgmii_rx_data.word == `XGMII_PREAMBLE_SFD)) begin
							rx_state			<= xgmii_rx_pkg::RX_BODY;
							rx_start			<= 1'b1;
							last_was_preamble	<= 1'b1;
						end else begin
							rx_state			<= xgmii_rx_pkg::RX_IDLE;
						end
					end

					xgmii_rx_pkg::RX_BODY: begin
						// Terminate in any lane closes the frame
						if (lane_has_end != '0) begin
							fcs_pending_0	<= 1'b1;
							rx_state		<= xgmii_rx_pkg::RX_IDLE;
						end
					end

					default: begin
						rx_state	<= xgmii_rx_pkg::RX_IDLE;
					end
				endcase

				// Error inside a frame wins over everything
				// Kills any FCS check still in flight
				if ((lane_has_error != '0) && (rx_state != xgmii_rx_pkg::RX_IDLE)) begin
					rx_state		<= xgmii_rx_pkg::RX_IDLE;
					rx_commit		<= 1'b0;
					rx_drop			<= 1'b1;
					fcs_pending_0	<= 1'b0;
					fcs_pending_1	<= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/crc32_eth_x32.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xgmii_rx_cfg.svh"

module crc32_eth_x32 (
	input wire							xgmii_rx_clk,
	input wire							crc_ce,
	input wire							crc_clear,

	// Leading crc_bytes bytes of crc_data are hashed, lane 3 first
	input wire [`XGMII_BYTES_W-1:0]		crc_bytes,
	input wire [31:0]					crc_data,

	// Complemented and byte-swapped, compares with the FCS as received
	output logic [31:0]					crc_out
);

	// Input stage
	logic [`XGMII_BYTES_W-1:0]	bytes_ff;
	logic [31:0]				data_ff;

	// Running reflected CRC
	logic [31:0]				crc_state;
	logic [31:0]				crc_next;

	// One byte into the reflected LFSR, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] din);
		logic [31:0] c;
		c = crc ^ {24'h0, din};
		for (int b = 0; b < 8; b++) begin
			c = c[0] ? ((c >> 1) ^ `CRC32_POLY) : (c >> 1);
		end
		return c;
	endfunction

	////////////////////
	// Fold 0 to 4 bytes

	always_comb begin
		crc_next = crc_state;
		// First wire byte sits in the top lane
		for (int k = 0; k < `XGMII_LANES; k++) begin
			if (k < int'(bytes_ff))
				crc_next = crc_byte(crc_next, data_ff[8*(`XGMII_LANES-1-k) +: 8]);
		end
	end

	////////////////////
	// Two register stages

	always_ff @(posedge xgmii_rx_clk) begin
		// Reseed works even while the bus stalls
		if (crc_clear) begin
			crc_state	<= `CRC32_INIT;
			bytes_ff	<= '0;
		end else if (crc_ce) begin
			bytes_ff	<= crc_bytes;
			data_ff		<= crc_data;
			crc_state	<= crc_next;
		end
	end

	// FCS goes out low byte first, inverted
	assign crc_out = ~{crc_state[7:0], crc_state[15:8], crc_state[23:16], crc_state[31:24]};

endmodule

`default_nettype wire

// ==== design/xgmii_rx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xgmii_rx_cfg.svh"

module xgmii_rx_mac (
	input wire								xgmii_rx_clk,
	input wire								reset,

	// XGMII receive side
	input wire								xgmii_rx_valid,
	input wire [`XGMII_LANES-1:0]			xgmii_rx_ctl,
	input wire xgmii_rx_pkg::xgmii_word_u	xgmii_rx_data,

	// Upper layer stream, act on data only after rx_commit
	output wire								rx_start,
	output wire								rx_data_valid,
	output wire [`XGMII_BYTES_W-1:0]		rx_bytes_valid,
	output wire [31:0]						rx_data,
	output wire								rx_commit,
	output wire								rx_drop
);

	wire [`XGMII_LANES-1:0]	lane_has_end;
	wire [`XGMII_LANES-1:0]	lane_has_error;
	wire					has_start;
	wire [31:0]				crc_out;
	wire					crc_ce;

	////////////////////
	// Lane decode

	xgmii_lane_decoder u_decoder (
		.xgmii_rx_ctl	(xgmii_rx_ctl),
		.xgmii_rx_data	(xgmii_rx_data),
		.lane_has_end	(lane_has_end),
		.lane_has_error	(lane_has_error),
		.has_start		(has_start)
	);

	////////////////////
	// Framing and FCS check

	eth_rx_framer u_framer (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.reset			(reset),
		.xgmii_rx_valid	(xgmii_rx_valid),
		.xgmii_rx_ctl	(xgmii_rx_ctl),
		.xgmii_rx_data	(xgmii_rx_data),
		.lane_has_end	(lane_has_end),
		.lane_has_error	(lane_has_error),
		.has_start		(has_start),
		.crc_out		(crc_out),
		.rx_start		(rx_start),
		.rx_data_valid	(rx_data_valid),
		.rx_bytes_valid	(rx_bytes_valid),
		.rx_data		(rx_data),
		.rx_commit		(rx_commit),
		.rx_drop		(rx_drop),
		.crc_ce			(crc_ce)
	);

	// CRC hashes exactly what goes upward, reseeded by each rx_start
	crc32_eth_x32 u_crc (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.crc_ce			(crc_ce),
		.crc_clear		(rx_start),
		.crc_bytes		(rx_bytes_valid),
		.crc_data		(rx_data),
		.crc_out		(crc_out)
	);

endmodule

`default_nettype wire

// ==== bench/xgmii_rx_mac_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xgmii_rx_cfg.svh"

module xgmii_rx_mac_asserts (
	input wire							xgmii_rx_clk,
	input wire							reset,
	input wire							rx_start,
	input wire							rx_data_valid,
	input wire [`XGMII_BYTES_W-1:0]		rx_bytes_valid,
	input wire							rx_commit,
	input wire							rx_drop
);

	////////////////////
	// Output strobes

	// A frame ends one way only
	commit_drop_exclusive: assert property (
		@(posedge xgmii_rx_clk) disable iff (reset)
		!(rx_commit && rx_drop)
	) else $error("rx_commit and rx_drop high together");

	// Start is a single-cycle pulse
	start_single_cycle: assert property (
		@(posedge xgmii_rx_clk) disable iff (reset)
		rx_start |=> !rx_start
	) else $error("rx_start held for more than one cycle");

	// First data word always comes after the start pulse
	start_before_data: assert property (
		@(posedge xgmii_rx_clk) disable iff (reset)
		!(rx_start && rx_data_valid)
	) else $error("rx_data_valid in the same cycle as rx_start");

	// At most one byte per lane
	bytes_in_range: assert property (
		@(posedge xgmii_rx_clk) disable iff (reset)
		rx_bytes_valid <= `XGMII_LANES
	) else $error("rx_bytes_valid above the lane count");

endmodule

`default_nettype wire

// ==== bench/xgmii_rx_mac_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "xgmii_rx_cfg.svh"

module xgmii_rx_mac_tb;

	localparam int MAX_WORDS	= 256;
	localparam int MAX_FRAMES	= 32;
	// Clean pass, then the same trace with random dead cycles
	localparam int PASSES		= 2;

	logic							xgmii_rx_clk;
	logic							reset;
	logic							xgmii_rx_valid;
	logic [`XGMII_LANES-1:0]		xgmii_rx_ctl;
	xgmii_rx_pkg::xgmii_word_u		xgmii_rx_data;
	wire							rx_start;
	wire							rx_data_valid;
	wire [`XGMII_BYTES_W-1:0]		rx_bytes_valid;
	wire [31:0]						rx_data;
	wire							rx_commit;
	wire							rx_drop;

	// Trace contents
	logic							in_valid [0:MAX_WORDS-1];
	logic [`XGMII_LANES-1:0]		in_ctl [0:MAX_WORDS-1];
	logic [31:0]					in_data [0:MAX_WORDS-1];
	string							exp_name [0:MAX_FRAMES-1];
	int								exp_total [0:MAX_FRAMES-1];
	int								exp_sum [0:MAX_FRAMES-1];
	logic							exp_commit [0:MAX_FRAMES-1];
	int								n_words;
	int								n_frames;
	logic							trace_loaded;

	// Frame being collected and error counts
	logic							frame_open;
	int								byte_total;
	int								byte_sum;
	int								results_seen;
	int								mismatch_count;
	int								protocol_count;
	integer							seed;

	xgmii_rx_mac uut (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.reset			(reset),
		.xgmii_rx_valid	(xgmii_rx_valid),
		.xgmii_rx_ctl	(xgmii_rx_ctl),
		.xgmii_rx_data	(xgmii_rx_data),
		.rx_start		(rx_start),
		.rx_data_valid	(rx_data_valid),
		.rx_bytes_valid	(rx_bytes_valid),
		.rx_data		(rx_data),
		.rx_commit		(rx_commit),
		.rx_drop		(rx_drop)
	);

	bind xgmii_rx_mac xgmii_rx_mac_asserts u_asserts (
		.xgmii_rx_clk	(xgmii_rx_clk),
		.reset			(reset),
		.rx_start		(rx_start),
		.rx_data_valid	(rx_data_valid),
		.rx_bytes_valid	(rx_bytes_valid),
		.rx_commit		(rx_commit),
		.rx_drop		(rx_drop)
	);

	// 8 ns period
	initial xgmii_rx_clk = 1'b0;
	always #4 xgmii_rx_clk = ~xgmii_rx_clk;

	////////////////////
	// Trace loading

	// Packed text from $sscanf is right aligned with leading nul bytes
	function automatic string text_of(input logic [8*24-1:0] packed_text);
		string s;
		s = "";
		for (int k = 23; k >= 0; k--) begin
			if (packed_text[8*k +: 8] != 8'h00)
				s = $sformatf("%s%c", s, packed_text[8*k +: 8]);
		end
		return s;
	endfunction

	task automatic parse_line(input logic [8*96-1:0] text);
		logic [8*8-1:0]		tag;
		logic [8*24-1:0]	name;
		logic [8*8-1:0]		outcome;
		logic [31:0]		v;
		logic [31:0]		c;
		logic [31:0]		d;
		int					total;
		int					sum;
		int					n;
		n = $sscanf(text, "%s", tag);
		if ((n == 1) && (tag == "i")) begin
			n = $sscanf(text, "%s %h %h %h", tag, v, c, d);
			if ((n == 4) && (n_words < MAX_WORDS)) begin
				in_valid[n_words]	= v[0];
				in_ctl[n_words]		= c[`XGMII_LANES-1:0];
				in_data[n_words]	= d;
				n_words++;
			end else begin
				$display("input line in the trace is malformed or the trace is too long");
				protocol_count++;
			end
		end else if ((n == 1) && (tag == "e")) begin
			n = $sscanf(text, "%s %s %d %d %s", tag, name, total, sum, outcome);
			if ((n == 5) && (n_frames < MAX_FRAMES)) begin
				exp_name[n_frames]		= text_of(name);
				exp_total[n_frames]		= total;
				exp_sum[n_frames]		= sum;
				exp_commit[n_frames]	= (outcome == "commit");
				n_frames++;
			end else begin
				$display("expect line in the trace is malformed or there are too many frames");
				protocol_count++;
			end
		end
		// Anything else is a comment
	endtask

	task automatic load_trace();
		integer				fd;
		integer				got;
		logic [8*96-1:0]	text;
		fd = $fopen("bench/xgmii_rx_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/xgmii_rx_trace.txt");
			protocol_count++;
		end else begin
			while (!$feof(fd)) begin
				text = '0;
				got = $fgets(text, fd);
				if (got > 0)
					parse_line(text);
			end
			$fclose(fd);
		end
	endtask

	////////////////////
	// Stimulus

	task automatic drive_word(input logic valid, input logic [3:0] ctl, input logic [31:0] data);
		@(posedge xgmii_rx_clk);
		#1;
		xgmii_rx_valid		= valid;
		xgmii_rx_ctl		= ctl;
		xgmii_rx_data.word	= data;
	endtask

	task automatic run_pass(input logic with_stalls, input int target);
		logic [31:0] rnd;
		logic [31:0] junk;
		for (int i = 0; i < n_words; i++) begin
			rnd = $random(seed);
			junk = $random(seed);
			// About one word in four gets a dead cycle ahead of it, with garbage on the bus
			if (with_stalls && (rnd[1:0] == 2'b00))
				drive_word(1'b0, rnd[7:4], junk);
			drive_word(in_valid[i], in_ctl[i], in_data[i]);
		end
		// Idle until the last FCS check of the pass has come out
		while (results_seen < target)
			drive_word(1'b1, {`XGMII_LANES{1'b1}}, {4{`XGMII_CTL_IDLE}});
	endtask

	////////////////////
	// Result collection

	// Leading bytes are the upper lanes
	function automatic int leading_byte_sum(input logic [31:0] word, input int count);
		int s;
		s = 0;
		for (int k = 0; k < count; k++)
			s = s + int'(word[31-8*k -: 8]);
		return s;
	endfunction

	task automatic begin_frame();
		if (frame_open) begin
			$display("rx_start came while the previous frame still had no result");
			protocol_count++;
		end
		frame_open	= 1'b1;
		byte_total	= 0;
		byte_sum	= 0;
	endtask

	task automatic take_word(input logic [31:0] word, input int count);
		if (!frame_open) begin
			$display("rx_data_valid was high outside a frame");
			protocol_count++;
		end else if ((count < 1) || (count > `XGMII_LANES)) begin
			$display("rx_bytes_valid was %0d on a valid data word", count);
			protocol_count++;
		end else begin
			byte_total	= byte_total + count;
			byte_sum	= byte_sum + leading_byte_sum(word, count);
		end
	endtask

	task automatic end_frame(input logic commit_seen);
		int idx;
		idx = results_seen % n_frames;
		if (!frame_open) begin
			$display("%0s came with no frame open", commit_seen ? "rx_commit" : "rx_drop");
			protocol_count++;
		end else begin
			if (byte_total != exp_total[idx]) begin
				$display("mismatch %0s byte total expected %0d actual %0d",
					exp_name[idx], exp_total[idx], byte_total);
				mismatch_count++;
			end
			if (byte_sum != exp_sum[idx]) begin
				$display("mismatch %0s byte sum expected %0d actual %0d",
					exp_name[idx], exp_sum[idx], byte_sum);
				mismatch_count++;
			end
			if (commit_seen != exp_commit[idx]) begin
				$display("mismatch %0s outcome expected %0s actual %0s", exp_name[idx],
					exp_commit[idx] ? "commit" : "drop", commit_seen ? "commit" : "drop");
				mismatch_count++;
			end
			frame_open = 1'b0;
			results_seen++;
		end
	endtask

	// Outputs settle well before the falling edge
	// Order matters when one frame ends as the next one starts
	always @(negedge xgmii_rx_clk) begin
		if (!reset && trace_loaded) begin
			if (rx_commit && rx_drop) begin
				$display("rx_commit and rx_drop were high in the same cycle");
				protocol_count++;
			end
			if (rx_commit || rx_drop)
				end_frame(rx_commit);
			if (rx_start)
				begin_frame();
			if (rx_data_valid)
				take_word(rx_data, int'(rx_bytes_valid));
		end
	end

	////////////////////
	// Main sequence

	initial begin
		xgmii_rx_valid		= 1'b0;
		xgmii_rx_ctl		= '0;
		xgmii_rx_data.word	= '0;
		reset				= 1'b1;
		seed				= 32'h4cb33054;
		n_words				= 0;
		n_frames			= 0;
		trace_loaded		= 1'b0;
		frame_open			= 1'b0;
		byte_total			= 0;
		byte_sum			= 0;
		results_seen		= 0;
		mismatch_count		= 0;
		protocol_count		= 0;

		load_trace();
		repeat (16) @(posedge xgmii_rx_clk);
		#1;
		reset = 1'b0;

		if ((n_words > 0) && (n_frames > 0) && (protocol_count == 0)) begin
			trace_loaded = 1'b1;
			run_pass(1'b0, n_frames);
			run_pass(1'b1, PASSES * n_frames);
			// A few more idles so a stray result still gets caught
			repeat (8) drive_word(1'b1, {`XGMII_LANES{1'b1}}, {4{`XGMII_CTL_IDLE}});
		end else begin
			$display("trace gave no usable input or expect lines");
			protocol_count++;
		end

		$display("%0d frame results checked, %0d mismatches, %0d other errors",
			results_seen, mismatch_count, protocol_count);
		if ((mismatch_count == 0) && (protocol_count == 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Worst case is one dead cycle per trace word in the stalled pass
	initial begin
		wait (trace_loaded);
		#((n_words * 3 * PASSES + 16 + 200) * 8);
		$display("timeout with %0d of %0d frame results seen", results_seen, PASSES * n_frames);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/xgmii_rx_trace.txt ====
# i valid ctl data: one bus cycle, hex, lane 3 (first byte on the wire) on the left
# e name bytes_delivered byte_sum_decimal commit|drop: result of the next frame
i 1 8 fb555555
i 1 0 555555d5
i 1 0 616263c2
i 1 1 412435fd
e abc_lane0 3 294 commit
i 1 8 fb555555
i 1 0 555555d5
i 1 0 6d657373
i 1 0 61676520
i 1 0 64696765
i 1 0 73747f9d
i 1 3 1520fd07
i 1 f 07070707
e digest_lane1 14 1413 commit
i 1 8 fb555555
i 1 0 555555d5
i 1 0 31323334
i 0 0 00000000
i 1 0 35363738
i 1 0 392639f4
i 1 7 cbfd0707
i 1 f 07070707
e digits_lane2 9 477 commit
i 1 8 fb555555
i 1 0 555555d5
i 1 0 00000000
i 1 0 1cdf4421
i 1 0 1cdf4421
i 1 f fd070707
i 1 f 07070707
e zeros_lane3 8 352 commit
i 1 8 fb555555
i 1 0 555555d5
i 1 0 31323334
i 1 0 35363738
i 1 0 392639f5
i 1 7 cbfd0707
i 1 f 07070707
e bad_fcs 9 477 drop
i 1 8 fb555555
i 1 0 555555d5
i 1 0 6d657373
i 1 0 61676520
i 1 2 6469fe65
i 1 0 73747f9d
i 1 3 1520fd07
i 1 f 07070707
e error_mid 4 440 drop
# wrong SFD, the frame must vanish without any result
i 1 8 fb555555
i 1 0 555555d4
i 1 0 616263c2
i 1 1 412435fd
i 1 f 07070707
i 1 8 fb555555
i 1 0 555555d5
i 1 0 616263c2
i 1 1 412435fd
i 1 f 07070707
i 1 f 07070707
e after_bad_pre 3 294 commit

// ==== files.f ====
+incdir+design
design/xgmii_rx_pkg.sv
design/xgmii_lane_decoder.sv
design/eth_rx_framer.sv
design/crc32_eth_x32.sv
design/xgmii_rx_mac.sv
bench/xgmii_rx_mac_asserts.sv
bench/xgmii_rx_mac_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator; the log decides the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module xgmii_rx_mac_tb -f files.f &&
./obj_dir/Vxgmii_rx_mac_tb | tee sim.log &&
! grep -q "Regression failed" sim.log &&
grep -q "Regression passed" sim.log &&
echo "simulation run ok" ||
{ echo "simulation run not ok"; exit 1; }
